/* Bender.yml */
package:
  name: tlb

sources:
  - tlb_pkg.sv
  - tlb_cmd_decode.sv
  - tlb_entry_array.sv
  - tlb_match.sv
  - tlb_cp0_regs.sv
  - tlb_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tlb_asserts.sv
      - tb_tlb.sv

/* sim.f */
tlb_pkg.sv
tlb_cmd_decode.sv
tlb_entry_array.sv
tlb_match.sv
tlb_cp0_regs.sv
tlb_top.sv
tb_clock_gen.sv
tlb_asserts.sv
tb_tlb.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD     = 10,
	parameter int RST_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset drops on the edge that ends the last reset cycle
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* tb_tlb.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_tlb;
	import tlb_pkg::*;

	localparam int NUM_ENTRIES = NUM_ENTRIES_DEFAULT;
	localparam int IDX_W       = $clog2(NUM_ENTRIES);
	localparam int PERIOD      = 10;

	// Strobes are {tlbwi, tlbr, tlbp}
	typedef struct packed {
		logic [2:0]       strobes;
		logic [IDX_W-1:0] index;
		reg_word_t        eh;
		reg_word_t        pm;
		reg_word_t        lo0;
		reg_word_t        lo1;
		reg_word_t        vi;
		reg_word_t        vd;
		logic             exp_hit;
	} row_t;

	logic clk, rst, tlbwi, tlbr, tlbp, probe_hit;
	logic [IDX_W-1:0] index, probe_index;
	reg_word_t entryhi, pagemask, entrylo0, entrylo1, vaddr_inst, vaddr_data;
	reg_word_t entryhi_out, entrylo0_out, entrylo1_out, paddr_inst, paddr_data;
	page_mask_t pagemask_out;

	// Shadow entries kept as the CP0 images that wrote them
	reg_word_t m_hi [NUM_ENTRIES];
	reg_word_t m_pm [NUM_ENTRIES];
	reg_word_t m_lo0 [NUM_ENTRIES];
	reg_word_t m_lo1 [NUM_ENTRIES];
	reg_word_t e_hi, e_lo0, e_lo1;
	page_mask_t e_pm;
	logic e_hit;
	logic [IDX_W-1:0] e_idx;

	row_t rows [$];
	logic [31:0] rng;
	int errors, checks;
	logic table_built = 1'b0;

	tb_clock_gen #(.PERIOD(PERIOD), .RST_CYCLES(3)) u_clock (.clk(clk), .rst(rst));

	tlb_top #(.NUM_ENTRIES(NUM_ENTRIES)) uut (
		.clk(clk), .rst(rst), .tlbwi(tlbwi), .tlbr(tlbr), .tlbp(tlbp), .index(index),
		.entryhi(entryhi), .pagemask(pagemask), .entrylo0(entrylo0), .entrylo1(entrylo1),
		.vaddr_inst(vaddr_inst), .vaddr_data(vaddr_data), .entryhi_out(entryhi_out),
		.pagemask_out(pagemask_out), .entrylo0_out(entrylo0_out),
		.entrylo1_out(entrylo1_out), .probe_hit(probe_hit), .probe_index(probe_index),
		.paddr_inst(paddr_inst), .paddr_data(paddr_data)
	);

	// ******************************
	// Stimulus helpers
	// ******************************

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic reg_word_t make_hi(vpn2_t vpn2, asid_t asid);
		return {vpn2, 5'b0, asid};
	endfunction

	function automatic reg_word_t make_lo(pfn_t pfn, cdv_t cdv, logic g);
		return {6'b0, pfn, cdv, g};
	endfunction

	function automatic reg_word_t make_va(vpn2_t vpn2, logic odd);
		return {vpn2, odd, 12'h000};
	endfunction

	function automatic void push_row(logic [2:0] s, logic [IDX_W-1:0] idx, reg_word_t eh,
		reg_word_t pm, reg_word_t lo0, reg_word_t lo1, reg_word_t vi, reg_word_t vd,
		logic hit);
		row_t r;
		r = '{s, idx, eh, pm, lo0, lo1, vi, vd, hit};
		rows.push_back(r);
	endfunction

	function automatic void write_row(logic [IDX_W-1:0] idx, reg_word_t eh, reg_word_t pm,
		reg_word_t lo0, reg_word_t lo1);
		push_row(3'b100, idx, eh, pm, lo0, lo1, '0, '0, 1'b0);
	endfunction

	function automatic void read_row(logic [IDX_W-1:0] idx);
		push_row(3'b010, idx, '0, '0, '0, '0, '0, '0, 1'b0);
	endfunction

	function automatic void probe_row(reg_word_t eh, logic hit);
		push_row(3'b001, '0, eh, '0, '0, '0, '0, '0, hit);
	endfunction

	function automatic void xlate_row(reg_word_t eh, reg_word_t vi, reg_word_t vd);
		push_row(3'b000, '0, eh, '0, '0, '0, vi, vd, 1'b0);
	endfunction

	function automatic void mixed_row(logic [2:0] s, logic [IDX_W-1:0] idx, reg_word_t eh,
		reg_word_t lo0, reg_word_t lo1);
		push_row(s, idx, eh, '0, lo0, lo1, '0, '0, 1'b0);
	endfunction

	task automatic build_table();
		read_row(5'd5);
		read_row(5'd31);
		probe_row(make_hi(19'h0, 8'h00), 1'b1);
		write_row(5'd3, make_hi(19'h12345, 8'h11), 32'h01ffe000,
			make_lo(20'habcde, 5'h1f, 1'b1), make_lo(20'h13579, 5'h0a, 1'b0));
		read_row(5'd3);
		write_row(5'd7, make_hi(19'h2468a, 8'h22), 32'h0,
			make_lo(20'h11111, 5'h07, 1'b1), make_lo(20'h22222, 5'h03, 1'b1));
		read_row(5'd7);
		probe_row(make_hi(19'h12345, 8'h11), 1'b1);
		probe_row(make_hi(19'h12345, 8'h22), 1'b0);
		probe_row(make_hi(19'h2468a, 8'h11), 1'b1);
		probe_row(make_hi(19'h7ffff, 8'h11), 1'b0);
		xlate_row(make_hi(19'h0, 8'h11), make_va(19'h12345, 0), make_va(19'h12345, 1));
		xlate_row(make_hi(19'h0, 8'h11), make_va(19'h2468a, 1), make_va(19'h55555, 0));
		xlate_row(make_hi(19'h0, 8'h22), make_va(19'h12345, 0), make_va(19'h0, 0));
		// Overlapping entries, the lower index must win
		write_row(5'd9, make_hi(19'h12345, 8'h11), 32'h0,
			make_lo(20'h0f0f0, 5'h02, 1'b1), make_lo(20'h0a0a0, 5'h04, 1'b0));
		probe_row(make_hi(19'h12345, 8'h11), 1'b1);
		xlate_row(make_hi(19'h0, 8'h11), make_va(19'h12345, 0), make_va(19'h12345, 1));
		write_row(5'd1, make_hi(19'h12345, 8'h33), 32'h0,
			make_lo(20'h55555, 5'h1f, 1'b1), make_lo(20'h66666, 5'h1f, 1'b1));
		probe_row(make_hi(19'h12345, 8'h11), 1'b1);
		xlate_row(make_hi(19'h0, 8'h11), make_va(19'h12345, 1), make_va(19'h2468a, 0));
		// Coinciding strobes
		mixed_row(3'b111, 5'd2, make_hi(19'h0abcd, 8'h11),
			make_lo(20'h77777, 5'h05, 1'b0), make_lo(20'h88888, 5'h06, 1'b0));
		mixed_row(3'b011, 5'd2, make_hi(19'h0abcd, 8'h11), '0, '0);
		probe_row(make_hi(19'h0abcd, 8'h11), 1'b1);
		write_row(5'd31, make_hi(19'h7ffff, 8'hff), 32'h00006000,
			make_lo(20'hfffff, 5'h1f, 1'b0), make_lo(20'hedcba, 5'h1f, 1'b1));
		read_row(5'd31);
		probe_row(make_hi(19'h7ffff, 8'hff), 1'b1);
		mixed_row(3'b101, 5'd4, make_hi(19'h01234, 8'h22),
			make_lo(20'h31415, 5'h09, 1'b1), make_lo(20'h92653, 5'h0c, 1'b0));
		probe_row(make_hi(19'h01234, 8'h22), 1'b1);
		xlate_row(make_hi(19'h0, 8'hff), make_va(19'h7ffff, 1), make_va(19'h01234, 0));
	endtask

	// ******************************
	// Shadow model
	// ******************************

	function automatic int find_entry(vpn2_t vpn2, asid_t asid);
		logic g;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			g = m_lo0[i][0] & m_lo1[i][0];
			if (m_hi[i][31:13] == vpn2 && (g || m_hi[i][7:0] == asid)) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic reg_word_t expect_paddr(asid_t asid, reg_word_t va);
		int k;
		k = find_entry(va[31:13], asid);
		if (k < 0) begin
			return {20'h0, va[11:0]};
		end else if (va[12]) begin
			return {m_lo1[k][25:6], va[11:0]};
		end else begin
			return {m_lo0[k][25:6], va[11:0]};
		end
	endfunction

	// Write beats read, read beats probe
	task automatic update_model(row_t r);
		int k;
		logic g;
		if (r.strobes[2]) begin
			m_hi[r.index] = r.eh;
			m_pm[r.index] = r.pm;
			m_lo0[r.index] = r.lo0;
			m_lo1[r.index] = r.lo1;
		end else if (r.strobes[1]) begin
			g = m_lo0[r.index][0] & m_lo1[r.index][0];
			e_hi = {m_hi[r.index][31:13], 5'b0, m_hi[r.index][7:0]};
			e_pm = m_pm[r.index][24:13];
			e_lo0 = {6'b0, m_lo0[r.index][25:1], g};
			e_lo1 = {6'b0, m_lo1[r.index][25:1], g};
		end else if (r.strobes[0]) begin
			k = find_entry(r.eh[31:13], r.eh[7:0]);
			e_hit = (k >= 0);
			e_idx = e_hit ? IDX_W'(k) : '0;
		end
	endtask

	// ******************************
	// Compare tasks
	// ******************************

	task automatic compare_word(string name, reg_word_t got, reg_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic compare_mask(string name, page_mask_t got, page_mask_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%03h expected 0x%03h", name, got, exp);
		end
	endtask

	task automatic compare_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	initial begin
		wait (table_built);
		#((rows.size() + 3 + 10) * PERIOD * 2);
		$display("Timeout: the stimulus table did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		row_t r;
		{tlbwi, tlbr, tlbp} = 3'b000;
		index = '0;
		{entryhi, pagemask, entrylo0, entrylo1} = '0;
		{vaddr_inst, vaddr_data} = '0;
		{e_hi, e_lo0, e_lo1, e_pm, e_hit, e_idx} = '0;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			{m_hi[i], m_pm[i], m_lo0[i], m_lo1[i]} = '0;
		end
		rng = 32'd35;
		errors = 0;
		checks = 0;
		build_table();
		table_built = 1'b1;
		wait (rst == 1'b0);
		#1;
		for (int n = 0; n < rows.size(); n++) begin
			r = rows[n];
			rng = xorshift32(rng);
			{tlbwi, tlbr, tlbp} = r.strobes;
			index = r.index;
			entryhi = r.eh;
			pagemask = r.pm;
			entrylo0 = r.lo0;
			entrylo1 = r.lo1;
			vaddr_inst = {r.vi[31:12], rng[11:0]};
			vaddr_data = {r.vd[31:12], rng[27:16]};
			// Translations settle well before the edge
			#4;
			compare_word("paddr_inst", paddr_inst, expect_paddr(r.eh[7:0], vaddr_inst));
			compare_word("paddr_data", paddr_data, expect_paddr(r.eh[7:0], vaddr_data));
			@(posedge clk);
			#1;
			update_model(r);
			compare_word("entryhi_out", entryhi_out, e_hi);
			compare_mask("pagemask_out", pagemask_out, e_pm);
			compare_word("entrylo0_out", entrylo0_out, e_lo0);
			compare_word("entrylo1_out", entrylo1_out, e_lo1);
			compare_bit("probe_hit", probe_hit, e_hit);
			compare_word("probe_index", reg_word_t'(probe_index), reg_word_t'(e_idx));
			if (r.strobes == 3'b001) begin
				compare_bit("probe_hit vs table", probe_hit, r.exp_hit);
			end
		end
		{tlbwi, tlbr, tlbp} = 3'b000;
		$display("Done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tlb_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_asserts #(
	parameter int NUM_ENTRIES = tlb_pkg::NUM_ENTRIES_DEFAULT
) (
	input logic                           clk,
	input logic                           rst,
	input logic                           probe_hit,
	input logic [$clog2(NUM_ENTRIES)-1:0] probe_index,
	input tlb_pkg::reg_word_t             vaddr_inst,
	input tlb_pkg::reg_word_t             paddr_inst,
	input tlb_pkg::reg_word_t             vaddr_data,
	input tlb_pkg::reg_word_t             paddr_data
);

	// No stale probe hit once reset has been seen
	a_reset_no_hit: assert property (@(posedge clk) rst |=> !probe_hit)
		else $error("probe_hit high in the cycle after reset");

	a_miss_index_zero: assert property (@(posedge clk) disable iff (rst)
		!probe_hit |-> (probe_index == '0))
		else $error("probe_index nonzero after a probe miss");

	// ******************************
	// Page offset passes through
	// ******************************

	a_offset_inst: assert property (@(posedge clk) disable iff (rst)
		paddr_inst[11:0] == vaddr_inst[11:0])
		else $error("paddr_inst offset differs from vaddr_inst");

	a_offset_data: assert property (@(posedge clk) disable iff (rst)
		paddr_data[11:0] == vaddr_data[11:0])
		else $error("paddr_data offset differs from vaddr_data");

endmodule

bind tlb_top tlb_asserts #(.NUM_ENTRIES(NUM_ENTRIES)) u_asserts (
	.clk         (clk),
	.rst         (rst),
	.probe_hit   (probe_hit),
	.probe_index (probe_index),
	.vaddr_inst  (vaddr_inst),
	.paddr_inst  (paddr_inst),
	.vaddr_data  (vaddr_data),
	.paddr_data  (paddr_data)
);

`default_nettype wire

/* tlb_cmd_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_cmd_decode (
	input  logic               tlbwi,
	input  logic               tlbr,
	input  logic               tlbp,
	input  tlb_pkg::reg_word_t entryhi,
	input  tlb_pkg::reg_word_t pagemask,
	input  tlb_pkg::reg_word_t entrylo0,
	input  tlb_pkg::reg_word_t entrylo1,
	output tlb_pkg::tlb_cmd_e  cmd,
	output tlb_pkg::tlb_entry_t wr_entry,
	output tlb_pkg::asid_t     key_asid
);
	import tlb_pkg::*;

	// Write beats read, read beats probe
	always_comb begin
		if (tlbwi) begin
			cmd = CMD_WRITE;
		end else if (tlbr) begin
			cmd = CMD_READ;
		end else if (tlbp) begin
			cmd = CMD_PROBE;
		end else begin
			cmd = CMD_NONE;
		end
	end

	// ******************************
	// CP0 images to entry fields
	// ******************************

	always_comb begin
		wr_entry.vpn2 = entryhi[31:13];
		wr_entry.asid = entryhi[7:0];
		wr_entry.mask = pagemask[24:13];

		// Entry is global only when both halves say so
		wr_entry.g = entrylo0[0] & entrylo1[0];

		wr_entry.even.pfn = entrylo0[25:6];
		wr_entry.even.cdv = entrylo0[5:1];
		wr_entry.odd.pfn  = entrylo1[25:6];
		wr_entry.odd.cdv  = entrylo1[5:1];
	end

	// Current ASID for every lookup
	assign key_asid = entryhi[7:0];

endmodule

`default_nettype wire

/* tlb_cp0_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_cp0_regs #(
	parameter int NUM_ENTRIES = tlb_pkg::NUM_ENTRIES_DEFAULT
) (
	input  logic                           clk,
	input  logic                           rst,
	input  tlb_pkg::tlb_cmd_e              cmd,
	input  tlb_pkg::tlb_entry_t            rd_entry,
	input  logic                           probe_hit_in,
	input  logic [$clog2(NUM_ENTRIES)-1:0] probe_index_in,
	output tlb_pkg::reg_word_t             entryhi_out,
	output tlb_pkg::page_mask_t            pagemask_out,
	output tlb_pkg::reg_word_t             entrylo0_out,
	output tlb_pkg::reg_word_t             entrylo1_out,
	output logic                           probe_hit,
	output logic [$clog2(NUM_ENTRIES)-1:0] probe_index
);
	import tlb_pkg::*;

	// ******************************
	// tlbr read-back
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			entryhi_out  <= '0;
			pagemask_out <= '0;
			entrylo0_out <= '0;
			entrylo1_out <= '0;
		end else if (cmd == CMD_READ) begin
			entryhi_out  <= {rd_entry.vpn2, 5'b0, rd_entry.asid};
			pagemask_out <= rd_entry.mask;
			// Global bit is mirrored into both entrylo images
			entrylo0_out <= {6'b0, rd_entry.even.pfn, rd_entry.even.cdv, rd_entry.g};
			entrylo1_out <= {6'b0, rd_entry.odd.pfn, rd_entry.odd.cdv, rd_entry.g};
		end
	end

	// ******************************
	// tlbp result
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			probe_hit   <= 1'b0;
			probe_index <= '0;
		end else if (cmd == CMD_PROBE) begin
			probe_hit <= probe_hit_in;
			if (probe_hit_in) begin
				probe_index <= probe_index_in;
			end else begin
				probe_index <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* tlb_entry_array.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_entry_array #(
	parameter int NUM_ENTRIES = tlb_pkg::NUM_ENTRIES_DEFAULT
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  tlb_pkg::tlb_cmd_e                     cmd,
	input  logic [$clog2(NUM_ENTRIES)-1:0]        index,
	input  tlb_pkg::tlb_entry_t                   wr_entry,
	output tlb_pkg::tlb_entry_t [NUM_ENTRIES-1:0] entries,
	output tlb_pkg::tlb_entry_t                   rd_entry
);
	import tlb_pkg::*;

	localparam int IDX_W = $clog2(NUM_ENTRIES);

	logic                           wr_en;
	logic [NUM_ENTRIES-1:0]         wr_sel;
	tlb_entry_t [NUM_ENTRIES-1:0]   mem;

	assign wr_en = (cmd == CMD_WRITE);

	// ******************************
	// Per-entry write enables
	// ******************************

	always_comb begin
		wr_sel = '0;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (wr_en && (index == IDX_W'(i))) begin
				wr_sel[i] = 1'b1;
			end
		end
	end

	// Entries live in flops, the matchers need all of them at once
	for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
		always_ff @(posedge clk) begin
			if (rst) begin
				mem[i] <= '0;
			end else if (wr_sel[i]) begin
				mem[i] <= wr_entry;
			end
		end
	end

	// ******************************
	// Outputs
	// ******************************

	assign entries = mem;

	// Indexed view for tlbr
	assign rd_entry = mem[index];

endmodule

`default_nettype wire

/* tlb_match.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_match #(
	parameter int NUM_ENTRIES = tlb_pkg::NUM_ENTRIES_DEFAULT
) (
	input  tlb_pkg::tlb_entry_t [NUM_ENTRIES-1:0] entries,
	input  tlb_pkg::vpn2_t                        key_vpn2,
	input  tlb_pkg::asid_t                        key_asid,
	input  logic                                  odd_sel,
	output logic                                  hit,
	output logic [$clog2(NUM_ENTRIES)-1:0]        hit_index,
	output tlb_pkg::pfn_t                         pfn
);
	import tlb_pkg::*;

	localparam int IDX_W = $clog2(NUM_ENTRIES);

	logic [NUM_ENTRIES-1:0] match;
	tlb_entry_t             sel_entry;

	// ******************************
	// Match vector
	// ******************************

	always_comb begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			match[i] = (entries[i].vpn2 == key_vpn2) &&
				(entries[i].g || (entries[i].asid == key_asid));
		end
	end

	// Scan downward so the lowest set bit is the last one kept
	always_comb begin
		hit       = 1'b0;
		hit_index = '0;
		for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit       = 1'b1;
				hit_index = IDX_W'(i);
			end
		end
	end

	// ******************************
	// Page frame select
	// ******************************

	assign sel_entry = entries[hit_index];

	always_comb begin
		if (!hit) begin
			pfn = '0;
		end else if (odd_sel) begin
			pfn = sel_entry.odd.pfn;
		end else begin
			pfn = sel_entry.even.pfn;
		end
	end

endmodule

`default_nettype wire

/* tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

	// ******************************
	// Field widths
	// ******************************

	typedef logic [31:0] reg_word_t;
	typedef logic [18:0] vpn2_t;
	typedef logic [7:0]  asid_t;
	typedef logic [19:0] pfn_t;

	// Cache attribute in bits 4:2, dirty in 1, valid in 0
	typedef logic [4:0]  cdv_t;

	typedef logic [11:0] page_mask_t;
	typedef logic [11:0] page_offset_t;

	// ******************************
	// Entry layout
	// ******************************

	// One half of a page pair
	typedef struct packed {
		pfn_t pfn;
		cdv_t cdv;
	} tlb_page_t;

	// Odd page sits in the low bits
	typedef struct packed {
		vpn2_t      vpn2;
		asid_t      asid;
		page_mask_t mask;
		logic       g;
		tlb_page_t  even;
		tlb_page_t  odd;
	} tlb_entry_t;

	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_WRITE = 2'd1,
		CMD_READ  = 2'd2,
		CMD_PROBE = 2'd3
	} tlb_cmd_e;

	localparam int NUM_ENTRIES_DEFAULT = 32;

endpackage

`default_nettype wire

/* tlb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_top #(
	parameter int NUM_ENTRIES = tlb_pkg::NUM_ENTRIES_DEFAULT
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           tlbwi,
	input  logic                           tlbr,
	input  logic                           tlbp,
	input  logic [$clog2(NUM_ENTRIES)-1:0] index,
	input  tlb_pkg::reg_word_t             entryhi,
	input  tlb_pkg::reg_word_t             pagemask,
	input  tlb_pkg::reg_word_t             entrylo0,
	input  tlb_pkg::reg_word_t             entrylo1,
	input  tlb_pkg::reg_word_t             vaddr_inst,
	input  tlb_pkg::reg_word_t             vaddr_data,
	output tlb_pkg::reg_word_t             entryhi_out,
	output tlb_pkg::page_mask_t            pagemask_out,
	output tlb_pkg::reg_word_t             entrylo0_out,
	output tlb_pkg::reg_word_t             entrylo1_out,
	output logic                           probe_hit,
	output logic [$clog2(NUM_ENTRIES)-1:0] probe_index,
	output tlb_pkg::reg_word_t             paddr_inst,
	output tlb_pkg::reg_word_t             paddr_data
);
	import tlb_pkg::*;

	localparam int IDX_W = $clog2(NUM_ENTRIES);

	tlb_cmd_e                     cmd;
	tlb_entry_t                   wr_entry;
	tlb_entry_t                   rd_entry;
	tlb_entry_t [NUM_ENTRIES-1:0] entries;
	asid_t                        key_asid;
	pfn_t                         pfn_inst;
	pfn_t                         pfn_data;
	page_offset_t                 off_inst;
	page_offset_t                 off_data;
	logic                         hit_probe;
	logic [IDX_W-1:0]             idx_probe;

	tlb_cmd_decode u_decode (
		.tlbwi    (tlbwi),
		.tlbr     (tlbr),
		.tlbp     (tlbp),
		.entryhi  (entryhi),
		.pagemask (pagemask),
		.entrylo0 (entrylo0),
		.entrylo1 (entrylo1),
		.cmd      (cmd),
		.wr_entry (wr_entry),
		.key_asid (key_asid)
	);

	tlb_entry_array #(.NUM_ENTRIES(NUM_ENTRIES)) u_array (
		.clk      (clk),
		.rst      (rst),
		.cmd      (cmd),
		.index    (index),
		.wr_entry (wr_entry),
		.entries  (entries),
		.rd_entry (rd_entry)
	);

	// ******************************
	// Lookups
	// ******************************

	// Bit 12 picks the odd page of the pair
	tlb_match #(.NUM_ENTRIES(NUM_ENTRIES)) u_match_inst (
		.entries   (entries),
		.key_vpn2  (vaddr_inst[31:13]),
		.key_asid  (key_asid),
		.odd_sel   (vaddr_inst[12]),
		.hit       (),
		.hit_index (),
		.pfn       (pfn_inst)
	);

	tlb_match #(.NUM_ENTRIES(NUM_ENTRIES)) u_match_data (
		.entries   (entries),
		.key_vpn2  (vaddr_data[31:13]),
		.key_asid  (key_asid),
		.odd_sel   (vaddr_data[12]),
		.hit       (),
		.hit_index (),
		.pfn       (pfn_data)
	);

	// Probe only needs hit and index
	tlb_match #(.NUM_ENTRIES(NUM_ENTRIES)) u_match_probe (
		.entries   (entries),
		.key_vpn2  (entryhi[31:13]),
		.key_asid  (key_asid),
		.odd_sel   (1'b0),
		.hit       (hit_probe),
		.hit_index (idx_probe),
		.pfn       ()
	);

	tlb_cp0_regs #(.NUM_ENTRIES(NUM_ENTRIES)) u_cp0_regs (
		.clk            (clk),
		.rst            (rst),
		.cmd            (cmd),
		.rd_entry       (rd_entry),
		.probe_hit_in   (hit_probe),
		.probe_index_in (idx_probe),
		.entryhi_out    (entryhi_out),
		.pagemask_out   (pagemask_out),
		.entrylo0_out   (entrylo0_out),
		.entrylo1_out   (entrylo1_out),
		.probe_hit      (probe_hit),
		.probe_index    (probe_index)
	);

	// ******************************
	// Physical addresses
	// ******************************

	assign off_inst = vaddr_inst[11:0];
	assign off_data = vaddr_data[11:0];

	// Matcher gives a zero frame on a miss
	assign paddr_inst = {pfn_inst, off_inst};
	assign paddr_data = {pfn_data, off_data};

endmodule

`default_nettype wire
